/* hdl/nbody_pkg.sv */
// nbody package
// shared widths, body limits, time step and enums for the integration
// datapath: Q16.16 state words, dt as a right shift, saturation bounds

package nbody_pkg;

	// fixed point format
	localparam int WORD_W    = 32;
	localparam int FRAC_BITS = 16;

	typedef logic signed [WORD_W-1:0] coord_t;

	// body slots
	localparam int MAX_BODIES = 8;
	localparam int BODY_W     = 3;

	typedef logic [BODY_W-1:0] body_idx_t;

	// dt = 2^-DT_SHIFT, i.e. 1/64
	localparam int DT_SHIFT = 6;

	// clamp bounds for every update
	localparam coord_t COORD_MAX = {1'b0, {(WORD_W-1){1'b1}}};
	localparam coord_t COORD_MIN = {1'b1, {(WORD_W-1){1'b0}}};

	// memory organisation, fields per body and axis banks
	localparam int NUM_FIELDS = 3;
	localparam int NUM_AXES   = 3;

	typedef enum logic [1:0] {
		F_POS = 2'd0,
		F_VEL = 2'd1,
		F_ACC = 2'd2
	} field_e;

	typedef enum logic [2:0] {
		S_WAIT     = 3'd0,
		S_VEL_RD   = 3'd1,
		S_VEL_CALC = 3'd2,
		S_VEL_WR   = 3'd3,
		S_POS_RD   = 3'd4,
		S_POS_CALC = 3'd5,
		S_POS_WR   = 3'd6,
		S_DONE     = 3'd7
	} step_state_e;

endpackage

/* hdl/body_mem.sv */
// body state memory
// three axis banks, each holding position, velocity and acceleration
// for every body slot; two registered read ports, one write port

`timescale 1ns/1ns

module body_mem import nbody_pkg::*;
(
	input  logic      CLK,
	input  field_e    rd_a_field_i,
	input  body_idx_t rd_a_body_i,
	input  field_e    rd_b_field_i,
	input  body_idx_t rd_b_body_i,
	input  logic      wr_en_i,
	input  field_e    wr_field_i,
	input  body_idx_t wr_body_i,
	input  coord_t    wr_x_i,
	input  coord_t    wr_y_i,
	input  coord_t    wr_z_i,
	output coord_t    rd_a_x_o,
	output coord_t    rd_a_y_o,
	output coord_t    rd_a_z_o,
	output coord_t    rd_b_x_o,
	output coord_t    rd_b_y_o,
	output coord_t    rd_b_z_o
);

// per-axis write data, x y z order
coord_t wr_data [NUM_AXES];

assign wr_data[0] = wr_x_i;
assign wr_data[1] = wr_y_i;
assign wr_data[2] = wr_z_i;

// one bank per axis, same addressing on all three
for (genvar ax = 0; ax < NUM_AXES; ax++)
begin : g_axis
	coord_t bank [NUM_FIELDS][MAX_BODIES];
	coord_t rd_a_q;
	coord_t rd_b_q;

	always_ff @(posedge CLK)
	begin
		if (wr_en_i)
		begin
			bank[wr_field_i][wr_body_i] <= wr_data[ax];
		end
		// read before write, data valid the next cycle
		rd_a_q <= bank[rd_a_field_i][rd_a_body_i];
		rd_b_q <= bank[rd_b_field_i][rd_b_body_i];
	end
end

assign rd_a_x_o = g_axis[0].rd_a_q;
assign rd_a_y_o = g_axis[1].rd_a_q;
assign rd_a_z_o = g_axis[2].rd_a_q;
assign rd_b_x_o = g_axis[0].rd_b_q;
assign rd_b_y_o = g_axis[1].rd_b_q;
assign rd_b_z_o = g_axis[2].rd_b_q;

// field code 3 has no storage behind it
a_wr_field_legal : assert property (@(posedge CLK)
	wr_en_i |-> wr_field_i inside {F_POS, F_VEL, F_ACC});

endmodule

/* hdl/mem_arbiter.sv */
// memory arbiter
// hands the body memory to the step controller while a step runs,
// otherwise to the host; returns host read data with a valid pulse

`timescale 1ns/1ns

module mem_arbiter import nbody_pkg::*;
(
	input  logic      CLK,
	input  logic      RESET,
	input  logic      busy_i,
	input  logic      host_we_i,
	input  logic      host_re_i,
	input  field_e    host_field_i,
	input  body_idx_t host_body_i,
	input  coord_t    host_wdata_x_i,
	input  coord_t    host_wdata_y_i,
	input  coord_t    host_wdata_z_i,
	input  field_e    ctl_rd_a_field_i,
	input  field_e    ctl_rd_b_field_i,
	input  body_idx_t ctl_body_i,
	input  logic      ctl_we_i,
	input  field_e    ctl_wr_field_i,
	input  coord_t    ctl_wdata_x_i,
	input  coord_t    ctl_wdata_y_i,
	input  coord_t    ctl_wdata_z_i,
	output field_e    mem_rd_a_field_o,
	output body_idx_t mem_rd_a_body_o,
	output field_e    mem_rd_b_field_o,
	output body_idx_t mem_rd_b_body_o,
	output logic      mem_wr_en_o,
	output field_e    mem_wr_field_o,
	output body_idx_t mem_wr_body_o,
	output coord_t    mem_wr_x_o,
	output coord_t    mem_wr_y_o,
	output coord_t    mem_wr_z_o,
	input  coord_t    rd_a_x_i,
	input  coord_t    rd_a_y_i,
	input  coord_t    rd_a_z_i,
	output logic      host_rvalid_o,
	output coord_t    host_rdata_x_o,
	output coord_t    host_rdata_y_o,
	output coord_t    host_rdata_z_o
);

// controller wins whenever a step is running
assign mem_rd_a_field_o = busy_i ? ctl_rd_a_field_i : host_field_i;
assign mem_rd_a_body_o  = busy_i ? ctl_body_i       : host_body_i;
assign mem_rd_b_field_o = busy_i ? ctl_rd_b_field_i : host_field_i;
assign mem_rd_b_body_o  = busy_i ? ctl_body_i       : host_body_i;

// host strobes during a step are simply dropped
assign mem_wr_en_o    = busy_i ? ctl_we_i       : host_we_i;
assign mem_wr_field_o = busy_i ? ctl_wr_field_i : host_field_i;
assign mem_wr_body_o  = busy_i ? ctl_body_i     : host_body_i;
assign mem_wr_x_o     = busy_i ? ctl_wdata_x_i  : host_wdata_x_i;
assign mem_wr_y_o     = busy_i ? ctl_wdata_y_i  : host_wdata_y_i;
assign mem_wr_z_o     = busy_i ? ctl_wdata_z_i  : host_wdata_z_i;

// port a output lines up with the registered valid
assign host_rdata_x_o = rd_a_x_i;
assign host_rdata_y_o = rd_a_y_i;
assign host_rdata_z_o = rd_a_z_i;

always_ff @(posedge CLK)
begin
	if (RESET)
		host_rvalid_o <= 1'b0;
	else
		host_rvalid_o <= host_re_i && !busy_i;
end

// controller writes only reach the memory while it holds the bus
a_ctl_wr_busy : assert property (@(posedge CLK) disable iff (RESET)
	ctl_we_i |-> busy_i);

endmodule

/* hdl/step_controller.sv */
// step controller
// walks the bodies one at a time: velocity update first, then position,
// each as read / calc / write; holds done until start is released

`timescale 1ns/1ns

module step_controller import nbody_pkg::*;
(
	input  logic      CLK,
	input  logic      RESET,
	input  logic      start_i,
	input  logic [3:0] num_bodies_i,
	output logic      done_o,
	output logic      busy_o,
	output logic      calc_en_o,
	output field_e    rd_a_field_o,
	output field_e    rd_b_field_o,
	output body_idx_t body_o,
	output logic      we_o,
	output field_e    wr_field_o
);

step_state_e state;
step_state_e next_state;
body_idx_t   body_q;
logic        last_body;

// a count of zero still leaves after the first slot
assign last_body = ({1'b0, body_q} + 4'd1) >= num_bodies_i;

always_ff @(posedge CLK)
begin
	if (RESET)
	begin
		state  <= S_WAIT;
		body_q <= '0;
		done_o <= 1'b0;
	end
	else
	begin
		state <= next_state;
		// registered from the state, rises one cycle into S_DONE
		done_o <= (state == S_DONE) && start_i;
		if (state == S_WAIT)
			body_q <= '0;
		else if (state == S_POS_WR && !last_body)
			body_q <= body_q + 1'b1;
	end
end

always_comb
begin
	next_state = state;
	unique case (state)
		S_WAIT:
		begin
			if (start_i)
				next_state = S_VEL_RD;
		end
		S_VEL_RD:   next_state = S_VEL_CALC;
		S_VEL_CALC: next_state = S_VEL_WR;
		S_VEL_WR:   next_state = S_POS_RD;
		S_POS_RD:   next_state = S_POS_CALC;
		S_POS_CALC: next_state = S_POS_WR;
		S_POS_WR:
		begin
			if (last_body)
				next_state = S_DONE;
			else
				next_state = S_VEL_RD;
		end
		S_DONE:
		begin
			if (!start_i)
				next_state = S_WAIT;
		end
		default:    next_state = S_WAIT;
	endcase
end

// read fields: port a is the rate, port b the base
always_comb
begin
	rd_a_field_o = F_ACC;
	rd_b_field_o = F_VEL;
	if (state == S_POS_RD)
	begin
		rd_a_field_o = F_VEL;
		rd_b_field_o = F_POS;
	end
end

assign busy_o     = (state != S_WAIT) && (state != S_DONE);
assign calc_en_o  = (state == S_VEL_CALC) || (state == S_POS_CALC);
assign we_o       = (state == S_VEL_WR) || (state == S_POS_WR);
assign wr_field_o = (state == S_VEL_WR) ? F_VEL : F_POS;
assign body_o     = body_q;

// every write must follow the calc cycle that produced its data
a_we_after_calc : assert property (@(posedge CLK) disable iff (RESET)
	we_o |-> $past(calc_en_o));

endmodule

/* hdl/axis_integrator.sv */
// one-axis integrator
// registers base + rate*dt, with dt a power of two, so the multiply is
// an arithmetic right shift; the sum clamps at the Q16.16 limits

`timescale 1ns/1ns

module axis_integrator import nbody_pkg::*;
(
	input  logic   CLK,
	input  logic   en_i,
	input  coord_t rate_i,
	input  coord_t base_i,
	output coord_t sum_o
);

coord_t                    rate_dt;
logic signed [WORD_W:0]    wide_sum;
coord_t                    clamped;

assign rate_dt = rate_i >>> DT_SHIFT;

// one guard bit catches overflow in either direction
assign wide_sum = {base_i[WORD_W-1], base_i} + {rate_dt[WORD_W-1], rate_dt};

always_comb
begin
	if (wide_sum[WORD_W] != wide_sum[WORD_W-1])
		clamped = wide_sum[WORD_W] ? COORD_MIN : COORD_MAX;
	else
		clamped = wide_sum[WORD_W-1:0];
end

always_ff @(posedge CLK)
begin
	if (en_i)
		sum_o <= clamped;
end

endmodule

/* hdl/nbody_top.sv */
// nbody integration top
// host port and step controller share the body memory via the arbiter;
// three integrators, one per axis, compute the new velocity or position

`timescale 1ns/1ns

module nbody_top import nbody_pkg::*;
(
	input  logic       CLK,
	input  logic       RESET,
	input  logic       start_i,
	input  logic [3:0] num_bodies_i,
	output logic       done_o,
	output logic       busy_o,
	input  logic       host_we_i,
	input  logic       host_re_i,
	input  field_e     host_field_i,
	input  body_idx_t  host_body_i,
	input  coord_t     host_wdata_x_i,
	input  coord_t     host_wdata_y_i,
	input  coord_t     host_wdata_z_i,
	output logic       host_rvalid_o,
	output coord_t     host_rdata_x_o,
	output coord_t     host_rdata_y_o,
	output coord_t     host_rdata_z_o
);

logic      calc_en;
logic      ctl_we;
field_e    ctl_rd_a_field;
field_e    ctl_rd_b_field;
field_e    ctl_wr_field;
body_idx_t ctl_body;

field_e    mem_rd_a_field;
field_e    mem_rd_b_field;
body_idx_t mem_rd_a_body;
body_idx_t mem_rd_b_body;
logic      mem_wr_en;
field_e    mem_wr_field;
body_idx_t mem_wr_body;
coord_t    mem_wr_x;
coord_t    mem_wr_y;
coord_t    mem_wr_z;

coord_t rd_a_x, rd_a_y, rd_a_z;
coord_t rd_b_x, rd_b_y, rd_b_z;
coord_t sum_x, sum_y, sum_z;

step_controller u_ctl (
	.CLK          (CLK),
	.RESET        (RESET),
	.start_i      (start_i),
	.num_bodies_i (num_bodies_i),
	.done_o       (done_o),
	.busy_o       (busy_o),
	.calc_en_o    (calc_en),
	.rd_a_field_o (ctl_rd_a_field),
	.rd_b_field_o (ctl_rd_b_field),
	.body_o       (ctl_body),
	.we_o         (ctl_we),
	.wr_field_o   (ctl_wr_field)
);

mem_arbiter u_arb (
	.CLK              (CLK),
	.RESET            (RESET),
	.busy_i           (busy_o),
	.host_we_i        (host_we_i),
	.host_re_i        (host_re_i),
	.host_field_i     (host_field_i),
	.host_body_i      (host_body_i),
	.host_wdata_x_i   (host_wdata_x_i),
	.host_wdata_y_i   (host_wdata_y_i),
	.host_wdata_z_i   (host_wdata_z_i),
	.ctl_rd_a_field_i (ctl_rd_a_field),
	.ctl_rd_b_field_i (ctl_rd_b_field),
	.ctl_body_i       (ctl_body),
	.ctl_we_i         (ctl_we),
	.ctl_wr_field_i   (ctl_wr_field),
	.ctl_wdata_x_i    (sum_x),
	.ctl_wdata_y_i    (sum_y),
	.ctl_wdata_z_i    (sum_z),
	.mem_rd_a_field_o (mem_rd_a_field),
	.mem_rd_a_body_o  (mem_rd_a_body),
	.mem_rd_b_field_o (mem_rd_b_field),
	.mem_rd_b_body_o  (mem_rd_b_body),
	.mem_wr_en_o      (mem_wr_en),
	.mem_wr_field_o   (mem_wr_field),
	.mem_wr_body_o    (mem_wr_body),
	.mem_wr_x_o       (mem_wr_x),
	.mem_wr_y_o       (mem_wr_y),
	.mem_wr_z_o       (mem_wr_z),
	.rd_a_x_i         (rd_a_x),
	.rd_a_y_i         (rd_a_y),
	.rd_a_z_i         (rd_a_z),
	.host_rvalid_o    (host_rvalid_o),
	.host_rdata_x_o   (host_rdata_x_o),
	.host_rdata_y_o   (host_rdata_y_o),
	.host_rdata_z_o   (host_rdata_z_o)
);

body_mem u_mem (
	.CLK          (CLK),
	.rd_a_field_i (mem_rd_a_field),
	.rd_a_body_i  (mem_rd_a_body),
	.rd_b_field_i (mem_rd_b_field),
	.rd_b_body_i  (mem_rd_b_body),
	.wr_en_i      (mem_wr_en),
	.wr_field_i   (mem_wr_field),
	.wr_body_i    (mem_wr_body),
	.wr_x_i       (mem_wr_x),
	.wr_y_i       (mem_wr_y),
	.wr_z_i       (mem_wr_z),
	.rd_a_x_o     (rd_a_x),
	.rd_a_y_o     (rd_a_y),
	.rd_a_z_o     (rd_a_z),
	.rd_b_x_o     (rd_b_x),
	.rd_b_y_o     (rd_b_y),
	.rd_b_z_o     (rd_b_z)
);

// port a carries the rate, port b the value being advanced
axis_integrator u_int_x (
	.CLK    (CLK),
	.en_i   (calc_en),
	.rate_i (rd_a_x),
	.base_i (rd_b_x),
	.sum_o  (sum_x)
);

axis_integrator u_int_y (
	.CLK    (CLK),
	.en_i   (calc_en),
	.rate_i (rd_a_y),
	.base_i (rd_b_y),
	.sum_o  (sum_y)
);

axis_integrator u_int_z (
	.CLK    (CLK),
	.en_i   (calc_en),
	.rate_i (rd_a_z),
	.base_i (rd_b_z),
	.sum_o  (sum_z)
);

endmodule

/* tests/tb_nbody.sv */
// nbody testbench
// loads body state over the host port, runs integration steps and
// compares the readback against a saturating Q16.16 model

`timescale 1ns/1ns

module tb_nbody import nbody_pkg::*;
();

localparam int     NUM_TESTS    = 6;
localparam int     SLOTS        = 8;
localparam int     DT_SH        = 6;
localparam longint SAT_HI       = 64'sh7FFF_FFFF;
localparam longint SAT_LO       = -64'sh8000_0000;
localparam int     DONE_LIMIT   = 80;
localparam int     RVALID_LIMIT = 4;

logic       CLK;
logic       RESET;
logic       start_i;
logic [3:0] num_bodies_i;
logic       done_o;
logic       busy_o;
logic       host_we_i;
logic       host_re_i;
field_e     host_field_i;
body_idx_t  host_body_i;
coord_t     host_wdata_x_i;
coord_t     host_wdata_y_i;
coord_t     host_wdata_z_i;
logic       host_rvalid_o;
coord_t     host_rdata_x_o;
coord_t     host_rdata_y_o;
coord_t     host_rdata_z_o;

// stimulus and expected state, one row per test
int     tbl_count     [NUM_TESTS];
bit     tbl_large     [NUM_TESTS];
bit     tbl_two_steps [NUM_TESTS];
bit     tbl_busy_wr   [NUM_TESTS];
coord_t tbl_pos       [NUM_TESTS][SLOTS][3];
coord_t tbl_vel       [NUM_TESTS][SLOTS][3];
coord_t tbl_acc       [NUM_TESTS][SLOTS][3];
coord_t tbl_exp_pos   [NUM_TESTS][SLOTS][3];
coord_t tbl_exp_vel   [NUM_TESTS][SLOTS][3];

int errors;
int tests_run;
int tests_failed;
bit aborted;

nbody_top uut (.*);

initial
begin
	CLK = 1'b0;
	forever #5 CLK = ~CLK;
end

// base + rate/64, clamped to the signed 32-bit range
function automatic coord_t sat_step(coord_t base, coord_t rate);
	longint sum;
	sum = longint'(base) + (longint'(rate) >>> DT_SH);
	if (sum > SAT_HI)
		return coord_t'(SAT_HI);
	if (sum < SAT_LO)
		return coord_t'(SAT_LO);
	return coord_t'(sum);
endfunction

// velocity first, then position from the new velocity
task automatic build_expected(int t);
	int     steps;
	coord_t v;
	coord_t p;
	steps = tbl_two_steps[t] ? 2 : 1;
	for (int b = 0; b < tbl_count[t]; b++)
		for (int a = 0; a < 3; a++)
		begin
			v = tbl_vel[t][b][a];
			p = tbl_pos[t][b][a];
			for (int s = 0; s < steps; s++)
			begin
				v = sat_step(v, tbl_acc[t][b][a]);
				p = sat_step(p, v);
			end
			tbl_exp_vel[t][b][a] = v;
			tbl_exp_pos[t][b][a] = p;
		end
endtask

task automatic fill_table();
	coord_t low;
	tbl_count     = '{1, 8, 5, 3, 4, 1};
	tbl_count[5]  = $urandom_range(SLOTS, 1);
	tbl_large     = '{1'b0, 1'b0, 1'b1, 1'b0, 1'b0, 1'b0};
	tbl_two_steps = '{1'b0, 1'b0, 1'b0, 1'b1, 1'b0, 1'b0};
	tbl_busy_wr   = '{1'b0, 1'b0, 1'b0, 1'b0, 1'b1, 1'b0};
	for (int t = 0; t < NUM_TESTS; t++)
	begin
		for (int b = 0; b < SLOTS; b++)
			for (int a = 0; a < 3; a++)
			begin
				low = $urandom & 32'h0000_FFFF;
				if (tbl_large[t] && (a + b) % 2 == 0)
				begin
					tbl_pos[t][b][a] = 32'h7FFF_0000 | low;
					tbl_vel[t][b][a] = 32'h7F00_0000 | low;
					tbl_acc[t][b][a] = 32'h7FFF_FFFF;
				end
				else if (tbl_large[t])
				begin
					tbl_pos[t][b][a] = 32'h8000_0000 | low;
					tbl_vel[t][b][a] = 32'h8100_0000 | low;
					tbl_acc[t][b][a] = 32'h8000_0000;
				end
				else
				begin
					// small enough that one step never clamps
					tbl_pos[t][b][a] = $signed($urandom) >>> 6;
					tbl_vel[t][b][a] = $signed($urandom) >>> 6;
					tbl_acc[t][b][a] = $signed($urandom) >>> 6;
				end
			end
		build_expected(t);
	end
endtask

task automatic host_write(field_e f, int b, coord_t x, coord_t y, coord_t z);
	host_we_i      = 1'b1;
	host_field_i   = f;
	host_body_i    = body_idx_t'(b);
	host_wdata_x_i = x;
	host_wdata_y_i = y;
	host_wdata_z_i = z;
	@(posedge CLK);
	#1;
	host_we_i = 1'b0;
endtask

task automatic host_read(field_e f, int b, output coord_t x, output coord_t y,
		output coord_t z);
	int n;
	host_re_i    = 1'b1;
	host_field_i = f;
	host_body_i  = body_idx_t'(b);
	@(posedge CLK);
	#1;
	host_re_i = 1'b0;
	n = 1;
	while (host_rvalid_o !== 1'b1 && n < RVALID_LIMIT)
	begin
		@(posedge CLK);
		#1;
		n++;
	end
	if (host_rvalid_o !== 1'b1)
	begin
		$display("host_rvalid_o never rose after a read of body %0d", b);
		errors++;
	end
	else if (n != 1)
	begin
		$display("FAILED host_rvalid_o latency: got 0x%0h expected 0x1", n);
		errors++;
	end
	x = host_rdata_x_o;
	y = host_rdata_y_o;
	z = host_rdata_z_o;
endtask

task automatic check_word(string sig, string what, int b, coord_t got, coord_t exp);
	if (got !== exp)
	begin
		$display("FAILED %s (%s, body %0d): got 0x%08h expected 0x%08h",
			sig, what, b, got, exp);
		errors++;
	end
endtask

task automatic check_vec(string what, int b, coord_t gx, coord_t gy, coord_t gz,
		coord_t ex, coord_t ey, coord_t ez);
	check_word("host_rdata_x_o", what, b, gx, ex);
	check_word("host_rdata_y_o", what, b, gy, ey);
	check_word("host_rdata_z_o", what, b, gz, ez);
endtask

task automatic check_reset_and_host();
	coord_t x, y, z;
	coord_t wx, wy, wz;
	int     errs_before;
	errs_before = errors;
	tests_run++;
	if (done_o !== 1'b0 || busy_o !== 1'b0 || host_rvalid_o !== 1'b0)
	begin
		$display("FAILED done_o/busy_o/host_rvalid_o after reset: got 0x%h%h%h expected 0x000",
			done_o, busy_o, host_rvalid_o);
		errors++;
	end
	wx = $urandom;
	wy = $urandom;
	wz = $urandom;
	host_write(F_VEL, 5, wx, wy, wz);
	host_read(F_VEL, 5, x, y, z);
	check_vec("vel", 5, x, y, z, wx, wy, wz);
	if (errors != errs_before)
		tests_failed++;
	$display("test 0 (reset and host access): %s", (errors == errs_before) ? "ok" : "fail");
endtask

task automatic run_step(int t);
	int cycles;
	int n_exp;
	start_i = 1'b1;
	@(posedge CLK);
	#1;
	cycles = 0;
	if (tbl_busy_wr[t])
	begin
		if (busy_o !== 1'b1)
		begin
			$display("FAILED busy_o one cycle after start: got 0x%h expected 0x1", busy_o);
			errors++;
		end
		// dropped by the arbiter, so the model leaves it out
		host_write(F_POS, 0, 32'hDEAD_BEEF, 32'h1234_5678, 32'hCAFE_F00D);
		cycles = 1;
	end
	while (done_o !== 1'b1 && cycles < DONE_LIMIT)
	begin
		@(posedge CLK);
		#1;
		cycles++;
	end
	if (done_o !== 1'b1)
	begin
		$display("timeout: done_o did not rise within %0d cycles in test %0d",
			DONE_LIMIT, t + 1);
		aborted = 1'b1;
		return;
	end
	n_exp = 6 * tbl_count[t] + 1;
	if (cycles != n_exp)
	begin
		$display("FAILED done_o latency: got 0x%0h expected 0x%0h", cycles, n_exp);
		errors++;
	end
	if (busy_o !== 1'b0)
	begin
		$display("FAILED busy_o at done: got 0x%h expected 0x0", busy_o);
		errors++;
	end
	// done has to hold as long as start does
	if (tbl_two_steps[t])
		repeat (3)
		begin
			@(posedge CLK);
			#1;
			if (done_o !== 1'b1)
			begin
				$display("FAILED done_o with start held: got 0x%h expected 0x1", done_o);
				errors++;
			end
		end
	start_i = 1'b0;
	cycles = 0;
	while (done_o !== 1'b0 && cycles < 4)
	begin
		@(posedge CLK);
		#1;
		cycles++;
	end
	if (done_o !== 1'b0)
	begin
		$display("timeout: done_o stayed high after start dropped in test %0d", t + 1);
		aborted = 1'b1;
	end
endtask

task automatic run_entry(int t);
	coord_t x, y, z;
	int     errs_before;
	errs_before = errors;
	tests_run++;
	for (int b = 0; b < tbl_count[t]; b++)
	begin
		host_write(F_POS, b, tbl_pos[t][b][0], tbl_pos[t][b][1], tbl_pos[t][b][2]);
		host_write(F_VEL, b, tbl_vel[t][b][0], tbl_vel[t][b][1], tbl_vel[t][b][2]);
		host_write(F_ACC, b, tbl_acc[t][b][0], tbl_acc[t][b][1], tbl_acc[t][b][2]);
	end
	num_bodies_i = 4'(tbl_count[t]);
	run_step(t);
	if (!aborted && tbl_two_steps[t])
		run_step(t);
	if (!aborted)
		for (int b = 0; b < tbl_count[t]; b++)
		begin
			host_read(F_POS, b, x, y, z);
			check_vec("pos", b, x, y, z, tbl_exp_pos[t][b][0], tbl_exp_pos[t][b][1],
				tbl_exp_pos[t][b][2]);
			host_read(F_VEL, b, x, y, z);
			check_vec("vel", b, x, y, z, tbl_exp_vel[t][b][0], tbl_exp_vel[t][b][1],
				tbl_exp_vel[t][b][2]);
			host_read(F_ACC, b, x, y, z);
			check_vec("acc", b, x, y, z, tbl_acc[t][b][0], tbl_acc[t][b][1],
				tbl_acc[t][b][2]);
		end
	if (aborted || errors != errs_before)
		tests_failed++;
	$display("test %0d (%0d bodies): %s", t + 1, tbl_count[t],
		(aborted || errors != errs_before) ? "fail" : "ok");
endtask

initial
begin
	void'($urandom(32'h2489));
	errors         = 0;
	tests_run      = 0;
	tests_failed   = 0;
	aborted        = 1'b0;
	RESET          = 1'b1;
	start_i        = 1'b0;
	num_bodies_i   = 4'd0;
	host_we_i      = 1'b0;
	host_re_i      = 1'b0;
	host_field_i   = F_POS;
	host_body_i    = '0;
	host_wdata_x_i = '0;
	host_wdata_y_i = '0;
	host_wdata_z_i = '0;
	fill_table();
	repeat (4) @(posedge CLK);
	#1;
	RESET = 1'b0;
	check_reset_and_host();
	for (int t = 0; t < NUM_TESTS && !aborted; t++)
		run_entry(t);
	$display("tests run %0d, tests failed %0d, check errors %0d",
		tests_run, tests_failed, errors);
	if (errors == 0 && tests_failed == 0 && !aborted)
		$display("SIMULATION PASSED");
	else
		$display("SIMULATION FAILED");
	$finish;
end

endmodule

/* files.f */
hdl/nbody_pkg.sv
hdl/body_mem.sv
hdl/mem_arbiter.sv
hdl/step_controller.sv
hdl/axis_integrator.sv
hdl/nbody_top.sv
tests/tb_nbody.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_nbody
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "SIMULATION FAILED" $(LOG); then echo "run failed"; exit 1; fi
	@if ! grep -q "SIMULATION PASSED" $(LOG); then echo "run ended early"; exit 1; fi

lint:
	$(VERILATOR) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
